// ==== dv/toll_plaza_assert.sv ====
/*
 * Concurrent checks on toll_plaza_top, attached with bind. Each failure
 * raises $error and is counted in fail_count for the testbench.
 */
`timescale 1ns/10ps

module toll_plaza_assert (
    input logic              clk,
    input logic              reset,
    input logic              arrive,
    input logic              tag_ok,
    input logic              result_valid,
    input toll_pkg::reject_e result_code,
    input logic              s_axi_bvalid,
    input logic              s_axi_bready,
    input logic              s_axi_rvalid,
    input logic              s_axi_rready
);
    import toll_pkg::*;

    int latency_fails = 0;
    int admit_fails = 0;
    int bhold_fails = 0;
    int rhold_fails = 0;
    int fail_count;

    assign fail_count = latency_fails + admit_fails + bhold_fails + rhold_fails;

    // Result valid exactly one cycle after each arrival
    latency_chk: assert property (@(posedge clk) disable iff (reset)
        result_valid == $past(arrive))
    else begin
        latency_fails++;
        $error("result_valid does not follow arrive by one cycle");
    end

    bad_tag_chk: assert property (@(posedge clk) disable iff (reset)
        (arrive && !tag_ok) |=> (result_code != RES_ADMIT))
    else begin
        admit_fails++;
        $error("vehicle with an invalid tag was admitted");
    end

    bvalid_hold_chk: assert property (@(posedge clk) disable iff (reset)
        (s_axi_bvalid && !s_axi_bready) |=> s_axi_bvalid)
    else begin
        bhold_fails++;
        $error("bvalid dropped before bready");
    end

    rvalid_hold_chk: assert property (@(posedge clk) disable iff (reset)
        (s_axi_rvalid && !s_axi_rready) |=> s_axi_rvalid)
    else begin
        rhold_fails++;
        $error("rvalid dropped before rready");
    end

endmodule

bind toll_plaza_top toll_plaza_assert u_assert (
    .clk(clk), .reset(reset), .arrive(arrive), .tag_ok(tag_ok),
    .result_valid(result_valid), .result_code(result_code),
    .s_axi_bvalid(s_axi_bvalid), .s_axi_bready(s_axi_bready),
    .s_axi_rvalid(s_axi_rvalid), .s_axi_rready(s_axi_rready)
);

// ==== dv/toll_plaza_tb.sv ====
/*
 * Directed testbench for toll_plaza_top. A reference model of the LFSR,
 * the tolls and the six lane counts predicts every vehicle result, and
 * AXI4-Lite reads check the register block.
 */
`timescale 1ns/10ps

module toll_plaza_tb;
    import toll_pkg::*;

    localparam int MAX_CYCLES = 2000;

    logic                clk = 1'b0;
    logic                reset;
    logic                arrive;
    vehicle_e            vh_type;
    logic [DIGIT_W-1:0]  tag_a, tag_b, tag_c, tag_d;
    logic                depart;
    logic [LANE_W-1:0]   depart_lane;
    logic                result_valid;
    reject_e             result_code;
    logic [LANE_W-1:0]   result_lane;
    logic [BAL_W-1:0]    result_balance;
    logic [ADDR_W-1:0]   s_axi_awaddr, s_axi_araddr;
    logic [DATA_W-1:0]   s_axi_wdata, s_axi_rdata;
    logic [DATA_W/8-1:0] s_axi_wstrb;
    logic                s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
    logic                s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
    logic                s_axi_rvalid, s_axi_rready;
    logic [1:0]          s_axi_bresp, s_axi_rresp;

    // Reference model state
    logic [BAL_W-1:0]    m_lfsr;
    logic [BAL_W-1:0]    m_toll [3];
    int                  m_occ [NUM_LANES];

    integer              seed;
    int                  cycle_count = 0;
    int                  error_count = 0;
    int                  check_count = 0;
    int                  test_count = 0;
    int                  failed_tests = 0;
    int                  errors_at_start;
    string               test_name;

    toll_plaza_top uut (.*);

    always #20 clk = ~clk;

    // All tests together take a few hundred cycles
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the DUT did not respond within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check(input string label, input logic [31:0] expected,
                         input logic [31:0] actual);
        check_count = check_count + 1;
        if (expected !== actual) begin
            error_count = error_count + 1;
            $display("Error: %s %s expected %0d actual %0d", test_name, label, expected, actual);
        end
    endtask

    // Luhn rule over the four digits, second and fourth doubled
    function automatic bit luhn_valid(input logic [3:0] a, b, c, d);
        int b2;
        int d2;
        int total;
        if (a > 4'd9 || b > 4'd9 || c > 4'd9 || d > 4'd9) begin
            return 1'b0;
        end
        b2 = 2 * int'(b);
        d2 = 2 * int'(d);
        total = int'(a) + b2 / 10 + b2 % 10 + int'(c) + d2 / 10 + d2 % 10;
        return (total % 10) == 0;
    endfunction

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = error_count;
    endtask

    task automatic report_test();
        int errs;
        errs = error_count - errors_at_start;
        test_count = test_count + 1;
        if (errs != 0) begin
            failed_tests = failed_tests + 1;
        end
        $display("%s finished with %0d errors", test_name, errs);
    endtask

    task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        s_axi_awaddr  <= addr;
        s_axi_wdata   <= data;
        s_axi_wstrb   <= 4'hf;
        s_axi_awvalid <= 1'b1;
        s_axi_wvalid  <= 1'b1;
        @(negedge clk);
        while (!(s_axi_awready && s_axi_wready)) @(negedge clk);
        @(posedge clk);
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid  <= 1'b0;
        @(negedge clk);
        while (!s_axi_bvalid) @(negedge clk);
        check("write response", 32'd0, 32'(s_axi_bresp));
        // Accept the response one cycle late so bvalid has to hold
        @(posedge clk);
        s_axi_bready <= 1'b1;
        @(posedge clk);
        s_axi_bready <= 1'b0;
        case (addr)
            8'h00: m_toll[0] = data[3:0];
            8'h04: m_toll[1] = data[3:0];
            8'h08: m_toll[2] = data[3:0];
            default: ;
        endcase
    endtask

    task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        s_axi_araddr  <= addr;
        s_axi_arvalid <= 1'b1;
        @(negedge clk);
        while (!s_axi_arready) @(negedge clk);
        @(posedge clk);
        s_axi_arvalid <= 1'b0;
        @(negedge clk);
        while (!s_axi_rvalid) @(negedge clk);
        data = s_axi_rdata;
        check("read response", 32'd0, 32'(s_axi_rresp));
        // Accept the data one cycle late so rvalid has to hold
        @(posedge clk);
        s_axi_rready <= 1'b1;
        @(posedge clk);
        s_axi_rready <= 1'b0;
    endtask

    task automatic expect_reg(input string label, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] expected);
        logic [DATA_W-1:0] rd;
        axi_read(addr, rd);
        check(label, expected, rd);
    endtask

    task automatic send_vehicle(input vehicle_e vtype, input logic [3:0] a, b, c, d,
                                output reject_e code_seen,
                                output logic [LANE_W-1:0] lane_seen,
                                output logic [BAL_W-1:0] bal_seen);
        int               base;
        int               exp_lane;
        reject_e          exp_code;
        logic [BAL_W-1:0] exp_bal;
        exp_bal  = m_lfsr;
        base     = 2 * int'(vtype);
        exp_lane = base;
        if (vtype != VH_NONE && m_occ[base] > m_occ[base + 1]) begin
            exp_lane = base + 1;
        end
        if (!luhn_valid(a, b, c, d)) begin
            exp_code = RES_BAD_TAG;
        end else if (vtype == VH_NONE) begin
            exp_code = RES_LANE_FULL;
        end else if (m_occ[base] == 7 && m_occ[base + 1] == 7) begin
            exp_code = RES_LANE_FULL;
        end else if (exp_bal < m_toll[int'(vtype)]) begin
            exp_code = RES_LOW_BALANCE;
        end else begin
            exp_code = RES_ADMIT;
        end
        arrive  <= 1'b1;
        vh_type <= vtype;
        tag_a   <= a;
        tag_b   <= b;
        tag_c   <= c;
        tag_d   <= d;
        @(posedge clk);
        arrive <= 1'b0;
        if (exp_code == RES_ADMIT) begin
            m_occ[exp_lane] = m_occ[exp_lane] + 1;
        end
        m_lfsr = (m_lfsr << 1) | BAL_W'(m_lfsr[3] ^ m_lfsr[2]);
        @(negedge clk);
        while (!result_valid) @(negedge clk);
        code_seen = result_code;
        lane_seen = result_lane;
        bal_seen  = result_balance;
        check("result code", 32'(exp_code), 32'(result_code));
        check("result lane", 32'(exp_lane), 32'(result_lane));
        check("result balance", 32'(exp_bal), 32'(result_balance));
        @(posedge clk);
    endtask

    task automatic depart_vehicle(input logic [LANE_W-1:0] lane);
        depart      <= 1'b1;
        depart_lane <= lane;
        @(posedge clk);
        depart <= 1'b0;
        if (m_occ[int'(lane)] > 0) begin
            m_occ[int'(lane)] = m_occ[int'(lane)] - 1;
        end
    endtask

    task automatic reset_values();
        int n;
        start_test("reset_values");
        @(negedge clk);
        check("result_valid after reset", 32'd0, 32'(result_valid));
        check("bvalid after reset", 32'd0, 32'(s_axi_bvalid));
        check("rvalid after reset", 32'd0, 32'(s_axi_rvalid));
        check("awready after reset", 32'd0, 32'(s_axi_awready));
        check("wready after reset", 32'd0, 32'(s_axi_wready));
        @(posedge clk);
        expect_reg("truck toll", 8'h00, 32'd5);
        expect_reg("car toll", 8'h04, 32'd4);
        expect_reg("bike toll", 8'h08, 32'd2);
        for (n = 0; n < NUM_LANES; n++) begin
            expect_reg("occupancy", ADDR_W'(8'h10 + 4 * n), 32'd0);
        end
        expect_reg("unmapped offset", 8'h0c, 32'd0);
        report_test();
    endtask

    task automatic tag_check();
        reject_e           code;
        logic [LANE_W-1:0] lane;
        logic [BAL_W-1:0]  bal;
        logic [31:0]       rnd;
        int                n;
        start_test("tag_check");
        send_vehicle(VH_BIKE, 4'd0, 4'd0, 4'd0, 4'd0, code, lane, bal);
        check("tag 0000 accepted", 32'd1, 32'(code != RES_BAD_TAG));
        send_vehicle(VH_BIKE, 4'd1, 4'd2, 4'd3, 4'd1, code, lane, bal);
        check("tag 1231 accepted", 32'd1, 32'(code != RES_BAD_TAG));
        send_vehicle(VH_BIKE, 4'd8, 4'd5, 4'd6, 4'd7, code, lane, bal);
        check("tag 8567 accepted", 32'd1, 32'(code != RES_BAD_TAG));
        send_vehicle(VH_BIKE, 4'd1, 4'd2, 4'd3, 4'd2, code, lane, bal);
        check("tag 1232 rejected", 32'(RES_BAD_TAG), 32'(code));
        send_vehicle(VH_BIKE, 4'd8, 4'd5, 4'd6, 4'd8, code, lane, bal);
        check("tag 8568 rejected", 32'(RES_BAD_TAG), 32'(code));
        // Sum is a multiple of 10 but the first digit is not BCD
        send_vehicle(VH_BIKE, 4'd10, 4'd0, 4'd0, 4'd0, code, lane, bal);
        check("non BCD digit rejected", 32'(RES_BAD_TAG), 32'(code));
        for (n = 0; n < 12; n++) begin
            rnd = $random(seed);
            send_vehicle(VH_BIKE, 4'(rnd[7:0] % 11), 4'(rnd[15:8] % 11),
                         4'(rnd[23:16] % 11), 4'(rnd[31:24] % 11), code, lane, bal);
        end
        report_test();
    endtask

    task automatic lane_balancing();
        reject_e           code;
        logic [LANE_W-1:0] lane;
        logic [BAL_W-1:0]  bal;
        int                n;
        start_test("lane_balancing");
        axi_write(8'h04, 32'd0);
        for (n = 0; n < 14; n++) begin
            send_vehicle(VH_CAR, 4'd1, 4'd2, 4'd3, 4'd1, code, lane, bal);
            check("car admitted", 32'(RES_ADMIT), 32'(code));
            check("car lane alternates", 32'(2 + n % 2), 32'(lane));
        end
        send_vehicle(VH_CAR, 4'd1, 4'd2, 4'd3, 4'd1, code, lane, bal);
        check("car lanes full", 32'(RES_LANE_FULL), 32'(code));
        for (n = 0; n < 2; n++) begin
            send_vehicle(VH_NONE, 4'd1, 4'd2, 4'd3, 4'd1, code, lane, bal);
            check("no vehicle type", 32'(RES_LANE_FULL), 32'(code));
        end
        report_test();
    endtask

    task automatic departures();
        int n;
        start_test("departures");
        depart_vehicle(3'd2);
        depart_vehicle(3'd2);
        depart_vehicle(3'd2);
        depart_vehicle(3'd3);
        depart_vehicle(3'd0);
        depart_vehicle(3'd5);
        for (n = 0; n < NUM_LANES; n++) begin
            expect_reg("occupancy", ADDR_W'(8'h10 + 4 * n), 32'(m_occ[n]));
        end
        expect_reg("empty lane stays at 0", 8'h10, 32'd0);
        expect_reg("lane 2 after three departures", 8'h18, 32'd4);
        report_test();
    endtask

    task automatic toll_and_balance();
        reject_e           code;
        logic [LANE_W-1:0] lane;
        logic [BAL_W-1:0]  bal;
        logic [BAL_W-1:0]  bal_model;
        int                n;
        int                admits;
        start_test("toll_and_balance");
        axi_write(8'h00, 32'd15);
        admits = 0;
        // One full LFSR period holds the value 15 exactly once
        for (n = 0; n < 15; n++) begin
            bal_model = m_lfsr;
            send_vehicle(VH_TRUCK, 4'd1, 4'd2, 4'd3, 4'd1, code, lane, bal);
            check("truck toll 15", 32'(bal_model == 4'd15 ? RES_ADMIT : RES_LOW_BALANCE),
                  32'(code));
            if (code == RES_ADMIT) begin
                admits = admits + 1;
            end
        end
        check("trucks admitted", 32'd1, 32'(admits));
        report_test();
    endtask

    initial begin
        seed          = 32'h4bd2e1ca;
        reset         = 1'b1;
        arrive        = 1'b0;
        vh_type       = VH_NONE;
        tag_a         = '0;
        tag_b         = '0;
        tag_c         = '0;
        tag_d         = '0;
        depart        = 1'b0;
        depart_lane   = '0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        m_lfsr        = 4'b0001;
        m_toll[0]     = 4'd5;
        m_toll[1]     = 4'd4;
        m_toll[2]     = 4'd2;
        for (int i = 0; i < NUM_LANES; i++) begin
            m_occ[i] = 0;
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        reset_values();
        tag_check();
        lane_balancing();
        departures();
        toll_and_balance();
        $display("Tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 test_count, failed_tests, check_count, error_count, uut.u_assert.fail_count);
        if (error_count == 0 && uut.u_assert.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== logic/fastag_check.sv ====
/*
 * Luhn check of a four-digit BCD FASTag number. Purely combinational,
 * tag_ok is valid whenever the digits are.
 */
`timescale 1ns/10ps

module fastag_check (
    input  logic [toll_pkg::DIGIT_W-1:0] tag_a,
    input  logic [toll_pkg::DIGIT_W-1:0] tag_b,
    input  logic [toll_pkg::DIGIT_W-1:0] tag_c,
    input  logic [toll_pkg::DIGIT_W-1:0] tag_d,
    output logic                         tag_ok
);
    import toll_pkg::*;

    // Doubled digit folded back to a single digit, 2*9 -> 9
    function automatic logic [DIGIT_W:0] luhn_double(input logic [DIGIT_W-1:0] digit);
        logic [DIGIT_W:0] twice;
        twice = {digit, 1'b0};
        if (twice > 5'd9) begin
            twice = twice - 5'd9;
        end
        return twice;
    endfunction

    logic [6:0] digit_sum;
    logic       digits_bcd;

    assign digits_bcd = (tag_a <= 4'd9) && (tag_b <= 4'd9) &&
                        (tag_c <= 4'd9) && (tag_d <= 4'd9);

    // Second and fourth digits are the doubled ones
    assign digit_sum = 7'(tag_a) + 7'(luhn_double(tag_b)) +
                       7'(tag_c) + 7'(luhn_double(tag_d));

    assign tag_ok = digits_bcd && ((digit_sum % 7'd10) == 7'd0);

endmodule

// ==== logic/lane_allocator.sv ====
/*
 * Six lane occupancy counters. Picks the less occupied lane of the pair
 * for the arriving type, counts admissions up and departures down.
 */
`timescale 1ns/10ps

module lane_allocator (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       arrive,
    input  toll_pkg::vehicle_e                         vh_type,
    input  logic                                       admit,
    input  logic                                       depart,
    input  logic [toll_pkg::LANE_W-1:0]                depart_lane,
    output logic [toll_pkg::LANE_W-1:0]                chosen_lane,
    output logic                                       lane_room,
    output logic [toll_pkg::NUM_LANES*toll_pkg::OCC_W-1:0] lane_occ
);
    import toll_pkg::*;

    logic [OCC_W-1:0]     occ [NUM_LANES];
    logic [OCC_W-1:0]     occ_lo;
    logic [OCC_W-1:0]     occ_hi;
    logic [NUM_LANES-1:0] inc_en;
    logic [NUM_LANES-1:0] dec_req;

    // Ties go to the even lane of the pair
    always_comb begin
        occ_lo      = '0;
        occ_hi      = '0;
        lane_room   = 1'b0;
        chosen_lane = {vh_type, 1'b0};
        if (vh_type != VH_NONE) begin
            occ_lo = occ[{vh_type, 1'b0}];
            occ_hi = occ[{vh_type, 1'b1}];
            if (occ_lo > occ_hi) begin
                chosen_lane = {vh_type, 1'b1};
            end
            lane_room = (occ_lo != OCC_MAX) || (occ_hi != OCC_MAX);
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            inc_en[i]  = arrive && admit && (chosen_lane == LANE_W'(i));
            dec_req[i] = depart && (depart_lane == LANE_W'(i));
            lane_occ[i*OCC_W +: OCC_W] = occ[i];
        end
    end

    // Arrival and departure on one lane cancel out
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                occ[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                case ({inc_en[i], dec_req[i]})
                    2'b10: occ[i] <= occ[i] + 1'b1;
                    2'b01: begin
                        if (occ[i] != '0) begin
                            occ[i] <= occ[i] - 1'b1;
                        end
                    end
                    default: occ[i] <= occ[i];
                endcase
            end
        end
    end

endmodule

// ==== logic/toll_payment.sv ====
/*
 * Balance LFSR, toll lookup and admission decision. The result of an
 * arrival is registered at the edge that samples it, one cycle latency.
 */
`timescale 1ns/10ps

module toll_payment (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        arrive,
    input  toll_pkg::vehicle_e          vh_type,
    input  logic                        tag_ok,
    input  logic                        lane_room,
    input  logic [toll_pkg::LANE_W-1:0] chosen_lane,
    input  logic [toll_pkg::BAL_W-1:0]  toll_truck,
    input  logic [toll_pkg::BAL_W-1:0]  toll_car,
    input  logic [toll_pkg::BAL_W-1:0]  toll_bike,
    output logic                        admit,
    output logic                        result_valid,
    output toll_pkg::reject_e           result_code,
    output logic [toll_pkg::LANE_W-1:0] result_lane,
    output logic [toll_pkg::BAL_W-1:0]  result_balance
);
    import toll_pkg::*;

    logic [BAL_W-1:0] lfsr;
    logic [BAL_W-1:0] toll;
    reject_e          code;

    always_comb begin
        case (vh_type)
            VH_TRUCK: toll = toll_truck;
            VH_CAR:   toll = toll_car;
            VH_BIKE:  toll = toll_bike;
            default:  toll = '0;
        endcase
    end

    // First failing check wins
    always_comb begin
        if (!tag_ok) begin
            code = RES_BAD_TAG;
        end else if (!lane_room) begin
            code = RES_LANE_FULL;
        end else if (lfsr < toll) begin
            code = RES_LOW_BALANCE;
        end else begin
            code = RES_ADMIT;
        end
    end

    assign admit = arrive && (code == RES_ADMIT);

    // x^4 + x^3 + 1, steps once per arrival
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr         <= LFSR_SEED;
            result_valid <= 1'b0;
        end else begin
            result_valid <= arrive;
            if (arrive) begin
                lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arrive) begin
            result_code    <= code;
            result_lane    <= chosen_lane;
            result_balance <= lfsr;
        end
    end

endmodule

// ==== logic/toll_pkg.sv ====
/*
 * Shared widths, default tolls, register offsets and enums for the
 * toll plaza controller. Modules import it inside their bodies and use
 * scoped names in their port lists.
 */
package toll_pkg;

    localparam int NUM_LANES = 6;
    localparam int LANE_W    = 3;
    localparam int OCC_W     = 3;
    localparam int BAL_W     = 4;
    localparam int DIGIT_W   = 4;

    localparam logic [OCC_W-1:0] OCC_MAX   = 3'd7;
    localparam logic [BAL_W-1:0] LFSR_SEED = 4'b0001;

    localparam logic [BAL_W-1:0] TOLL_TRUCK_DEF = 4'd5;
    localparam logic [BAL_W-1:0] TOLL_CAR_DEF   = 4'd4;
    localparam logic [BAL_W-1:0] TOLL_BIKE_DEF  = 4'd2;

    // AXI4-Lite register map, byte offsets
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;
    localparam logic [ADDR_W-1:0] REG_TOLL_TRUCK = 8'h00;
    localparam logic [ADDR_W-1:0] REG_TOLL_CAR   = 8'h04;
    localparam logic [ADDR_W-1:0] REG_TOLL_BIKE  = 8'h08;
    localparam logic [ADDR_W-1:0] REG_OCC_BASE   = 8'h10;

    // Lane pair n serves type n, VH_NONE has no lanes
    typedef enum logic [1:0] {
        VH_TRUCK = 2'd0,
        VH_CAR   = 2'd1,
        VH_BIKE  = 2'd2,
        VH_NONE  = 2'd3
    } vehicle_e;

    typedef enum logic [1:0] {
        RES_ADMIT, RES_BAD_TAG, RES_LANE_FULL, RES_LOW_BALANCE
    } reject_e;

endpackage

// ==== logic/toll_plaza_top.sv ====
/*
 * Toll plaza controller top level. Connects tag check, lane allocation,
 * payment and the AXI4-Lite register block.
 */
`timescale 1ns/10ps

module toll_plaza_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          arrive,
    input  toll_pkg::vehicle_e            vh_type,
    input  logic [toll_pkg::DIGIT_W-1:0]  tag_a,
    input  logic [toll_pkg::DIGIT_W-1:0]  tag_b,
    input  logic [toll_pkg::DIGIT_W-1:0]  tag_c,
    input  logic [toll_pkg::DIGIT_W-1:0]  tag_d,
    input  logic                          depart,
    input  logic [toll_pkg::LANE_W-1:0]   depart_lane,
    output logic                          result_valid,
    output toll_pkg::reject_e             result_code,
    output logic [toll_pkg::LANE_W-1:0]   result_lane,
    output logic [toll_pkg::BAL_W-1:0]    result_balance,
    input  logic [toll_pkg::ADDR_W-1:0]   s_axi_awaddr,
    input  logic                          s_axi_awvalid,
    output logic                          s_axi_awready,
    input  logic [toll_pkg::DATA_W-1:0]   s_axi_wdata,
    input  logic [toll_pkg::DATA_W/8-1:0] s_axi_wstrb,
    input  logic                          s_axi_wvalid,
    output logic                          s_axi_wready,
    output logic [1:0]                    s_axi_bresp,
    output logic                          s_axi_bvalid,
    input  logic                          s_axi_bready,
    input  logic [toll_pkg::ADDR_W-1:0]   s_axi_araddr,
    input  logic                          s_axi_arvalid,
    output logic                          s_axi_arready,
    output logic [toll_pkg::DATA_W-1:0]   s_axi_rdata,
    output logic [1:0]                    s_axi_rresp,
    output logic                          s_axi_rvalid,
    input  logic                          s_axi_rready
);
    import toll_pkg::*;

    logic                         tag_ok;
    logic                         lane_room;
    logic                         admit;
    logic [LANE_W-1:0]            chosen_lane;
    logic [BAL_W-1:0]             toll_truck;
    logic [BAL_W-1:0]             toll_car;
    logic [BAL_W-1:0]             toll_bike;
    logic [NUM_LANES*OCC_W-1:0]   lane_occ;

    fastag_check u_fastag (
        .tag_a (tag_a), .tag_b (tag_b), .tag_c (tag_c), .tag_d (tag_d),
        .tag_ok(tag_ok)
    );

    lane_allocator u_lanes (
        .clk(clk), .reset(reset), .arrive(arrive), .vh_type(vh_type), .admit(admit),
        .depart(depart), .depart_lane(depart_lane), .chosen_lane(chosen_lane),
        .lane_room(lane_room), .lane_occ(lane_occ)
    );

    toll_payment u_payment (
        .clk(clk), .reset(reset), .arrive(arrive), .vh_type(vh_type), .tag_ok(tag_ok),
        .lane_room(lane_room), .chosen_lane(chosen_lane), .toll_truck(toll_truck),
        .toll_car(toll_car), .toll_bike(toll_bike), .admit(admit),
        .result_valid(result_valid), .result_code(result_code),
        .result_lane(result_lane), .result_balance(result_balance)
    );

    toll_regs u_regs (
        .clk(clk), .reset(reset),
        .s_axi_awaddr(s_axi_awaddr), .s_axi_awvalid(s_axi_awvalid),
        .s_axi_awready(s_axi_awready), .s_axi_wdata(s_axi_wdata),
        .s_axi_wstrb(s_axi_wstrb), .s_axi_wvalid(s_axi_wvalid),
        .s_axi_wready(s_axi_wready), .s_axi_bresp(s_axi_bresp),
        .s_axi_bvalid(s_axi_bvalid), .s_axi_bready(s_axi_bready),
        .s_axi_araddr(s_axi_araddr), .s_axi_arvalid(s_axi_arvalid),
        .s_axi_arready(s_axi_arready), .s_axi_rdata(s_axi_rdata),
        .s_axi_rresp(s_axi_rresp), .s_axi_rvalid(s_axi_rvalid),
        .s_axi_rready(s_axi_rready), .lane_occ(lane_occ),
        .toll_truck(toll_truck), .toll_car(toll_car), .toll_bike(toll_bike)
    );

endmodule

// ==== logic/toll_regs.sv ====
/*
 * AXI4-Lite slave for the toll rates and lane occupancies.
 * Toll registers are read/write, occupancy registers are read only.
 * Responses are always OKAY, unmapped reads return 0.
 */
`timescale 1ns/10ps

module toll_regs (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic [toll_pkg::ADDR_W-1:0]                    s_axi_awaddr,
    input  logic                                           s_axi_awvalid,
    output logic                                           s_axi_awready,
    input  logic [toll_pkg::DATA_W-1:0]                    s_axi_wdata,
    input  logic [toll_pkg::DATA_W/8-1:0]                  s_axi_wstrb,
    input  logic                                           s_axi_wvalid,
    output logic                                           s_axi_wready,
    output logic [1:0]                                     s_axi_bresp,
    output logic                                           s_axi_bvalid,
    input  logic                                           s_axi_bready,
    input  logic [toll_pkg::ADDR_W-1:0]                    s_axi_araddr,
    input  logic                                           s_axi_arvalid,
    output logic                                           s_axi_arready,
    output logic [toll_pkg::DATA_W-1:0]                    s_axi_rdata,
    output logic [1:0]                                     s_axi_rresp,
    output logic                                           s_axi_rvalid,
    input  logic                                           s_axi_rready,
    input  logic [toll_pkg::NUM_LANES*toll_pkg::OCC_W-1:0] lane_occ,
    output logic [toll_pkg::BAL_W-1:0]                     toll_truck,
    output logic [toll_pkg::BAL_W-1:0]                     toll_car,
    output logic [toll_pkg::BAL_W-1:0]                     toll_bike
);
    import toll_pkg::*;

    logic              wr_ready;
    logic              wr_fire;
    logic              rd_fire;
    logic [DATA_W-1:0] rd_word;

    // Address and data are taken together in one beat
    assign s_axi_awready = wr_ready;
    assign s_axi_wready  = wr_ready;
    assign wr_fire       = wr_ready && s_axi_awvalid && s_axi_wvalid;
    assign s_axi_bresp   = 2'b00;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ready     <= 1'b0;
            s_axi_bvalid <= 1'b0;
        end else begin
            wr_ready <= !wr_ready && s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid;
            if (wr_fire) begin
                s_axi_bvalid <= 1'b1;
            end else if (s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
        end
    end

    // Only the low nibble is kept, occupancy offsets ignore writes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            toll_truck <= TOLL_TRUCK_DEF;
            toll_car   <= TOLL_CAR_DEF;
            toll_bike  <= TOLL_BIKE_DEF;
        end else if (wr_fire && s_axi_wstrb[0]) begin
            case (s_axi_awaddr)
                REG_TOLL_TRUCK: toll_truck <= s_axi_wdata[BAL_W-1:0];
                REG_TOLL_CAR:   toll_car   <= s_axi_wdata[BAL_W-1:0];
                REG_TOLL_BIKE:  toll_bike  <= s_axi_wdata[BAL_W-1:0];
                default: ;
            endcase
        end
    end

    // Read channel
    assign s_axi_arready = !s_axi_rvalid;
    assign rd_fire       = s_axi_arvalid && s_axi_arready;
    assign s_axi_rresp   = 2'b00;

    always_comb begin
        rd_word = '0;
        case (s_axi_araddr)
            REG_TOLL_TRUCK: rd_word = DATA_W'(toll_truck);
            REG_TOLL_CAR:   rd_word = DATA_W'(toll_car);
            REG_TOLL_BIKE:  rd_word = DATA_W'(toll_bike);
            default: begin
                for (int i = 0; i < NUM_LANES; i++) begin
                    if (s_axi_araddr == ADDR_W'(REG_OCC_BASE + 4 * i)) begin
                        rd_word = DATA_W'(lane_occ[i*OCC_W +: OCC_W]);
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s_axi_rvalid <= 1'b0;
        end else if (rd_fire) begin
            s_axi_rvalid <= 1'b1;
        end else if (s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            s_axi_rdata <= rd_word;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the toll plaza testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module toll_plaza_tb -f toll_plaza.f -o toll_plaza_sim
status=0
./obj_dir/toll_plaza_sim +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit "$status"

// ==== toll_plaza.f ====
logic/toll_pkg.sv
logic/fastag_check.sv
logic/lane_allocator.sv
logic/toll_payment.sv
logic/toll_regs.sv
logic/toll_plaza_top.sv
dv/toll_plaza_assert.sv
dv/toll_plaza_tb.sv
